/* hw/fe_pkg.sv */
package fe_pkg;

  // address and instruction widths, translation is identity
  localparam int vaddr_width_lp = 32;
  localparam int instr_width_lp = 32;
  // one fetch returns a pair of words, so the sequential step is 8 bytes
  localparam int fetch_bytes_lp = 8;

  // RISC-V major opcodes that end a fetch pair
  localparam logic [6:0] rv_opc_branch_lp = 7'b1100011;
  localparam logic [6:0] rv_opc_jal_lp    = 7'b1101111;
  localparam logic [6:0] rv_opc_jalr_lp   = 7'b1100111;

  // back end command opcodes
  typedef enum logic [0:0]
  {
    e_op_redirect = 1'b0,
    e_op_wait     = 1'b1
  } fe_opcode_e;

  // command from the back end, 33 bits
  typedef struct packed
  {
    fe_opcode_e                opcode;
    logic [vaddr_width_lp-1:0] vaddr;
  } fe_cmd_s;

  // queue message kind
  typedef enum logic [0:0]
  {
    e_fe_fetch     = 1'b0,
    e_fe_exception = 1'b1
  } fe_msg_type_e;

  // exception codes carried in a queue message
  typedef enum logic [1:0]
  {
    e_instr_misaligned   = 2'd0,
    e_instr_access_fault = 2'd1,
    e_exc_none           = 2'd2
  } fe_exc_e;

  // one lane of the fetch queue, 67 bits
  // instr is zero for an exception
  typedef struct packed
  {
    fe_msg_type_e              msg_type;
    logic [vaddr_width_lp-1:0] pc;
    logic [instr_width_lp-1:0] instr;
    fe_exc_e                   exc_code;
  } fe_queue_s;

  // memory response for a pair, 65 bits
  typedef struct packed
  {
    logic [instr_width_lp-1:0] instr0;
    logic [instr_width_lp-1:0] instr1;
    logic                      err;
  } fe_resp_s;

  // IF2 contents handed to the packer, 98 bits
  typedef struct packed
  {
    logic [vaddr_width_lp-1:0] pc;
    logic [instr_width_lp-1:0] instr0;
    logic [instr_width_lp-1:0] instr1;
    logic                      err;
    logic                      valid;
  } fe_if2_s;

endpackage

/* hw/fe_fetch_ctrl.sv */
`timescale 1ns/1ps

module fe_fetch_ctrl
  (input  logic                              clk_i
  , input  logic                             reset_i
  , input  fe_pkg::fe_cmd_s                  fe_cmd_i
  , input  logic                             fe_cmd_v_i
  , output logic                             fe_cmd_yumi_o
  , output logic                             fetch_req_v_o
  , output logic [fe_pkg::vaddr_width_lp-1:0] fetch_pc_o
  , input  logic                             fetch_req_ready_i
  , input  logic                             fe_queue_ready_i
  , input  logic                             deliver_fail_i
  , input  logic                             squash_resteer_i
  , input  logic [fe_pkg::vaddr_width_lp-1:0] resteer_pc_i
  , input  logic                             exc_sent_i
  , input  logic [fe_pkg::vaddr_width_lp-1:0] if2_pc_i
  , output logic                             req_accept_o
  , output logic                             poison_o
  , output logic                             misaligned_v_o
  , output logic [fe_pkg::vaddr_width_lp-1:0] misaligned_pc_o
  );

  import fe_pkg::*;

  typedef enum logic [1:0] {e_wait, e_run, e_stall} state_e;

  state_e                    state_r, state_n;
  logic [vaddr_width_lp-1:0] next_pc_r, next_pc_n;
  logic [vaddr_width_lp-1:0] resume_pc_r;
  logic [vaddr_width_lp-1:0] misaligned_pc_r;
  logic                      misaligned_pending_r;
  logic                      redirect_v, wait_v, target_misaligned, unstall;

  // a command is taken unless a misaligned exception still waits for the queue
  assign fe_cmd_yumi_o     = fe_cmd_v_i & ~misaligned_pending_r;
  assign redirect_v        = fe_cmd_yumi_o & (fe_cmd_i.opcode == e_op_redirect);
  assign wait_v            = fe_cmd_yumi_o & (fe_cmd_i.opcode == e_op_wait);
  assign target_misaligned = |fe_cmd_i.vaddr[1:0];
  assign unstall           = (state_r == e_stall) & fe_queue_ready_i;

  // requests go out only while running
  assign fetch_req_v_o = (state_r == e_run);
  assign fetch_pc_o    = next_pc_r;
  assign req_accept_o  = fetch_req_v_o & fetch_req_ready_i;

  // kill the request taken this cycle on any change of flow
  // the IF2 item of this cycle has already been resolved by the packer
  assign poison_o = fe_cmd_yumi_o | squash_resteer_i | deliver_fail_i | exc_sent_i;

  assign misaligned_v_o  = misaligned_pending_r;
  assign misaligned_pc_o = misaligned_pc_r;

  // commands win over every event coming back from the packer
  always_comb
  begin
    state_n = state_r;
    if (redirect_v)
      state_n = target_misaligned ? e_wait : e_run;
    else if (wait_v)
      state_n = e_wait;
    else
    begin
      case (state_r)
        // an access fault ends the run and only a redirect restarts it
        e_run:
          if (exc_sent_i)
            state_n = e_wait;
          else if (deliver_fail_i)
            state_n = e_stall;
        // leave as soon as the queue can take data again
        e_stall:
          if (fe_queue_ready_i)
            state_n = e_run;
        default:
          state_n = state_r;
      endcase
    end
  end

  // next pc prefers the load sources over the sequential step
  always_comb
  begin
    next_pc_n = next_pc_r;
    if (redirect_v)
      next_pc_n = fe_cmd_i.vaddr;
    else if (squash_resteer_i)
      next_pc_n = resteer_pc_i;
    else if (unstall)
      next_pc_n = resume_pc_r;
    else if (req_accept_o)
      next_pc_n = next_pc_r + vaddr_width_lp'(fetch_bytes_lp);
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r              <= e_wait;
      misaligned_pending_r <= 1'b0;
    end
    else
    begin
      state_r <= state_n;
      // pending exception lives until the packer reports it sent
      if (redirect_v & target_misaligned)
        misaligned_pending_r <= 1'b1;
      else if (misaligned_pending_r & exc_sent_i)
        misaligned_pending_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    next_pc_r <= next_pc_n;
    // dropped pair is refetched from here after the stall
    if (deliver_fail_i)
      resume_pc_r <= if2_pc_i;
    if (redirect_v)
      misaligned_pc_r <= fe_cmd_i.vaddr;
  end

  // a misaligned target never reaches memory, every load path keeps word alignment
  a_req_pc_aligned: assert property (@(posedge clk_i) disable iff (reset_i)
    fetch_req_v_o |-> (fetch_pc_o[1:0] == 2'b00));

  a_no_req_with_misaligned: assert property (@(posedge clk_i) disable iff (reset_i)
    misaligned_v_o |-> !fetch_req_v_o);

endmodule

/* hw/fe_fetch_stage.sv */
`timescale 1ns/1ps

module fe_fetch_stage
  (input  logic                              clk_i
  , input  logic                             reset_i
  , input  logic                             req_accept_i
  , input  logic [fe_pkg::vaddr_width_lp-1:0] req_pc_i
  , input  logic                             poison_i
  , input  fe_pkg::fe_resp_s                 fetch_resp_i
  , output fe_pkg::fe_if2_s                  if2_o
  );

  import fe_pkg::*;

  logic                      if2_v_r;
  logic [vaddr_width_lp-1:0] if2_pc_r;

  // IF1 is the request accepted this cycle
  // a poisoned one is never promoted and its memory answer is ignored
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      if2_v_r <= 1'b0;
    else
      if2_v_r <= req_accept_i & ~poison_i;
  end

  // pc of the pair whose response arrives next cycle
  always_ff @(posedge clk_i)
  begin
    if (req_accept_i)
      if2_pc_r <= req_pc_i;
  end

  // the fixed one-cycle latency lines the response up with the IF2 pc
  always_comb
  begin
    if2_o.pc     = if2_pc_r;
    if2_o.instr0 = fetch_resp_i.instr0;
    if2_o.instr1 = fetch_resp_i.instr1;
    if2_o.err    = fetch_resp_i.err;
    if2_o.valid  = if2_v_r;
  end

endmodule

/* hw/fe_queue_pack.sv */
`timescale 1ns/1ps

module fe_queue_pack
  (input  fe_pkg::fe_if2_s                   if2_i
  , input  logic                             fe_queue_ready_i
  , input  logic                             misaligned_v_i
  , input  logic [fe_pkg::vaddr_width_lp-1:0] misaligned_pc_i
  , output fe_pkg::fe_queue_s                fe_queue_o1
  , output fe_pkg::fe_queue_s                fe_queue_o2
  , output logic                             fe_queue_v_o1
  , output logic                             fe_queue_v_o2
  , output logic                             deliver_fail_o
  , output logic                             squash_resteer_o
  , output logic [fe_pkg::vaddr_width_lp-1:0] resteer_pc_o
  , output logic                             exc_sent_o
  );

  import fe_pkg::*;

  logic [6:0]                lane1_opc;
  logic                      lane1_branch;
  logic                      if2_live;
  logic [vaddr_width_lp-1:0] lane2_pc;

  // scan lane 1 for anything that changes flow
  assign lane1_opc    = if2_i.instr0[6:0];
  assign lane1_branch = (lane1_opc == rv_opc_branch_lp)
                      | (lane1_opc == rv_opc_jal_lp)
                      | (lane1_opc == rv_opc_jalr_lp);

  // misaligned exception has priority over the IF2 pair
  assign if2_live = if2_i.valid & ~misaligned_v_i;
  assign lane2_pc = if2_i.pc + vaddr_width_lp'(instr_width_lp / 8);

  // valids rise only while ready and lane 2 only with lane 1
  always_comb
  begin
    fe_queue_v_o1 = fe_queue_ready_i & (misaligned_v_i | if2_i.valid);
    fe_queue_v_o2 = fe_queue_ready_i & if2_live & ~if2_i.err & ~lane1_branch;
  end

  // lane 1 carries a fetch unless one of the exceptions applies
  always_comb
  begin
    fe_queue_o1.msg_type = e_fe_fetch;
    fe_queue_o1.pc       = if2_i.pc;
    fe_queue_o1.instr    = if2_i.instr0;
    fe_queue_o1.exc_code = e_exc_none;
    if (misaligned_v_i)
    begin
      fe_queue_o1.msg_type = e_fe_exception;
      fe_queue_o1.pc       = misaligned_pc_i;
      fe_queue_o1.instr    = '0;
      fe_queue_o1.exc_code = e_instr_misaligned;
    end
    else if (if2_i.err)
    begin
      fe_queue_o1.msg_type = e_fe_exception;
      fe_queue_o1.instr    = '0;
      fe_queue_o1.exc_code = e_instr_access_fault;
    end
  end

  // lane 2 is always a plain fetch of the second word
  always_comb
  begin
    fe_queue_o2.msg_type = e_fe_fetch;
    fe_queue_o2.pc       = lane2_pc;
    fe_queue_o2.instr    = if2_i.instr1;
    fe_queue_o2.exc_code = e_exc_none;
  end

  // feedback to the controller
  assign deliver_fail_o   = if2_live & ~fe_queue_ready_i;
  assign squash_resteer_o = if2_live & fe_queue_ready_i & ~if2_i.err & lane1_branch;
  // fetch restarts right behind lane 1 after a branch
  assign resteer_pc_o     = lane2_pc;
  assign exc_sent_o       = fe_queue_v_o1 & (misaligned_v_i | if2_i.err);

endmodule

/* hw/fe_top.sv */
`timescale 1ns/1ps

module fe_top
  (input  logic                              clk_i
  , input  logic                             reset_i
  // back end commands
  , input  fe_pkg::fe_cmd_s                  fe_cmd_i
  , input  logic                             fe_cmd_v_i
  , output logic                             fe_cmd_yumi_o
  // instruction memory request
  , output logic                             fetch_req_v_o
  , output logic [fe_pkg::vaddr_width_lp-1:0] fetch_pc_o
  , input  logic                             fetch_req_ready_i
  // instruction memory response, one cycle after the request
  , input  fe_pkg::fe_resp_s                 fetch_resp_i
  // fetch queue, two lanes sharing one ready
  , output fe_pkg::fe_queue_s                fe_queue_o1
  , output fe_pkg::fe_queue_s                fe_queue_o2
  , output logic                             fe_queue_v_o1
  , output logic                             fe_queue_v_o2
  , input  logic                             fe_queue_ready_i
  );

  import fe_pkg::*;

  logic                      req_accept;
  logic                      poison;
  logic                      misaligned_v;
  logic [vaddr_width_lp-1:0] misaligned_pc;
  logic                      deliver_fail;
  logic                      squash_resteer;
  logic [vaddr_width_lp-1:0] resteer_pc;
  logic                      exc_sent;
  fe_if2_s                   if2;

  // state machine, pc and command handling
  fe_fetch_ctrl ctrl
    (.clk_i             (clk_i)
    , .reset_i          (reset_i)
    , .fe_cmd_i         (fe_cmd_i)
    , .fe_cmd_v_i       (fe_cmd_v_i)
    , .fe_cmd_yumi_o    (fe_cmd_yumi_o)
    , .fetch_req_v_o    (fetch_req_v_o)
    , .fetch_pc_o       (fetch_pc_o)
    , .fetch_req_ready_i(fetch_req_ready_i)
    , .fe_queue_ready_i (fe_queue_ready_i)
    , .deliver_fail_i   (deliver_fail)
    , .squash_resteer_i (squash_resteer)
    , .resteer_pc_i     (resteer_pc)
    , .exc_sent_i       (exc_sent)
    , .if2_pc_i         (if2.pc)
    , .req_accept_o     (req_accept)
    , .poison_o         (poison)
    , .misaligned_v_o   (misaligned_v)
    , .misaligned_pc_o  (misaligned_pc)
    );

  // IF2 register, joins the memory response to its pc
  fe_fetch_stage stage
    (.clk_i        (clk_i)
    , .reset_i     (reset_i)
    , .req_accept_i(req_accept)
    , .req_pc_i    (fetch_pc_o)
    , .poison_i    (poison)
    , .fetch_resp_i(fetch_resp_i)
    , .if2_o       (if2)
    );

  // builds the two lane messages and reports back
  fe_queue_pack pack
    (.if2_i            (if2)
    , .fe_queue_ready_i(fe_queue_ready_i)
    , .misaligned_v_i  (misaligned_v)
    , .misaligned_pc_i (misaligned_pc)
    , .fe_queue_o1     (fe_queue_o1)
    , .fe_queue_o2     (fe_queue_o2)
    , .fe_queue_v_o1   (fe_queue_v_o1)
    , .fe_queue_v_o2   (fe_queue_v_o2)
    , .deliver_fail_o  (deliver_fail)
    , .squash_resteer_o(squash_resteer)
    , .resteer_pc_o    (resteer_pc)
    , .exc_sent_o      (exc_sent)
    );

endmodule

/* tests/fe_tb.sv */
`timescale 1ns/1ps

module fe_tb;

  import fe_pkg::*;

  localparam int stim_depth_lp   = 64;
  localparam int max_exp_lp      = 16;
  localparam int cmd_timeout_lp  = 50;
  localparam int msg_timeout_lp  = 400;
  localparam int quiet_cycles_lp = 20;

  logic                      clk_i;
  logic                      reset_i;
  fe_cmd_s                   fe_cmd_i;
  logic                      fe_cmd_v_i;
  logic                      fe_cmd_yumi_o;
  logic                      fetch_req_v_o;
  logic [vaddr_width_lp-1:0] fetch_pc_o;
  logic                      fetch_req_ready_i;
  fe_resp_s                  fetch_resp_i;
  fe_queue_s                 fe_queue_o1;
  fe_queue_s                 fe_queue_o2;
  logic                      fe_queue_v_o1;
  logic                      fe_queue_v_o2;
  logic                      fe_queue_ready_i;

  // records are tag, pc and word, see the data file
  logic [67:0] stim [0:stim_depth_lp-1];
  logic [31:0] image [logic [31:0]];
  fe_queue_s   exp_q [0:max_exp_lp-1];
  int          exp_cnt;
  int          exp_rd;
  logic [31:0] rng;
  logic        bp_on;
  logic        hold_queue;
  logic        cmd_pending;
  fe_cmd_s     cmd_next;
  logic        resp_due;
  logic [31:0] resp_pc;
  int          errors;
  int          test_errors;
  int          tests_run;
  int          tests_failed;
  int          idx;
  int          test_num;
  logic [67:0] hdr;

  fe_top DUT
    (.clk_i             (clk_i)
    , .reset_i          (reset_i)
    , .fe_cmd_i         (fe_cmd_i)
    , .fe_cmd_v_i       (fe_cmd_v_i)
    , .fe_cmd_yumi_o    (fe_cmd_yumi_o)
    , .fetch_req_v_o    (fetch_req_v_o)
    , .fetch_pc_o       (fetch_pc_o)
    , .fetch_req_ready_i(fetch_req_ready_i)
    , .fetch_resp_i     (fetch_resp_i)
    , .fe_queue_o1      (fe_queue_o1)
    , .fe_queue_o2      (fe_queue_o2)
    , .fe_queue_v_o1    (fe_queue_v_o1)
    , .fe_queue_v_o2    (fe_queue_v_o2)
    , .fe_queue_ready_i (fe_queue_ready_i)
    );

  initial
  begin
    clk_i = 1'b0;
    forever
      #5 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // pair read, err when either word lies outside the image
  function automatic fe_resp_s answer_fetch(input logic [31:0] pc);
    fe_resp_s r;
    r.instr0 = image.exists(pc) ? image[pc] : 32'h0;
    r.instr1 = image.exists(pc + 32'd4) ? image[pc + 32'd4] : 32'h0;
    r.err    = !image.exists(pc) || !image.exists(pc + 32'd4);
    return r;
  endfunction

  // tag 2 is a fetch, tag 3 an exception with its code in the low bits
  function automatic fe_queue_s expected_msg(input logic [67:0] rec);
    fe_queue_s m;
    m.pc = rec[63:32];
    if (rec[67:64] == 4'h2)
    begin
      m.msg_type = e_fe_fetch;
      m.instr    = rec[31:0];
      m.exc_code = e_exc_none;
    end
    else
    begin
      m.msg_type = e_fe_exception;
      m.instr    = '0;
      m.exc_code = fe_exc_e'(rec[1:0]);
    end
    return m;
  endfunction

  // one transferred lane against the head of the expected list
  task automatic check_lane(input string name, input fe_queue_s got);
    assert (exp_rd < exp_cnt)
    else
    begin
      $display("unexpected message on %s at pc %h", name, got.pc);
      test_errors++;
    end
    if (exp_rd < exp_cnt)
    begin
      assert (got == exp_q[exp_rd])
      else
      begin
        $display("FAIL %s expected %h got %h", name, exp_q[exp_rd], got);
        test_errors++;
      end
      exp_rd++;
    end
  endtask

  // one clock cycle, inputs at the falling edge, outputs sampled just before the rise
  task automatic tick();
    @(negedge clk_i);
    // memory answers the request accepted in the previous cycle
    if (resp_due)
      fetch_resp_i = answer_fetch(resp_pc);
    else
      fetch_resp_i = '0;
    rng = xorshift32(rng);
    fe_queue_ready_i  = hold_queue ? 1'b0 : (bp_on ? |rng[1:0] : 1'b1);
    fetch_req_ready_i = bp_on ? |rng[3:2] : 1'b1;
    fe_cmd_v_i = cmd_pending;
    fe_cmd_i   = cmd_next;
    #4;
    if (fe_queue_v_o1)
      check_lane("fe_queue_o1", fe_queue_o1);
    if (fe_queue_v_o2)
      check_lane("fe_queue_o2", fe_queue_o2);
    resp_due = fetch_req_v_o & fetch_req_ready_i;
    resp_pc  = fetch_pc_o;
    if (fe_cmd_v_i & fe_cmd_yumi_o)
      cmd_pending = 1'b0;
  endtask

  // hold valid until yumi
  task automatic send_cmd(input fe_opcode_e op, input logic [31:0] vaddr);
    int n;
    cmd_next.opcode = op;
    cmd_next.vaddr  = vaddr;
    cmd_pending = 1'b1;
    n = 0;
    while (cmd_pending && n < cmd_timeout_lp)
    begin
      tick();
      n++;
    end
    assert (!cmd_pending)
    else
    begin
      $display("command at %h was never taken by the front end", vaddr);
      test_errors++;
      cmd_pending = 1'b0;
    end
  endtask

  task automatic wait_messages();
    int n;
    n = 0;
    while (exp_rd < exp_cnt && n < msg_timeout_lp)
    begin
      tick();
      n++;
    end
    assert (exp_rd == exp_cnt)
    else
    begin
      $display("timed out with %0d of %0d messages delivered", exp_rd, exp_cnt);
      test_errors++;
    end
  endtask

  // flags: bit 0 opcode, bit 4 back-pressure, bit 8 wait command after the stream
  task automatic run_test(input logic [67:0] rec, input int num);
    logic [31:0] target;
    logic [31:0] flags;
    target      = rec[63:32];
    flags       = rec[31:0];
    test_errors = 0;
    bp_on       = flags[4];
    send_cmd(flags[0] ? e_op_wait : e_op_redirect, target);
    wait_messages();
    if (flags[8])
    begin
      // queue held low so the pair in flight cannot slip out beside the wait
      hold_queue = 1'b1;
      send_cmd(e_op_wait, 32'h0);
      hold_queue = 1'b0;
    end
    // anything delivered from here on is unexpected
    bp_on = 1'b0;
    repeat (quiet_cycles_lp)
      tick();
    tests_run++;
    errors += test_errors;
    if (test_errors == 0)
      $display("test %0d at %h passed, %0d messages", num, target, exp_cnt);
    else
    begin
      tests_failed++;
      $display("test %0d at %h failed, %0d errors", num, target, test_errors);
    end
  endtask

  initial
  begin
    reset_i           = 1'b1;
    fe_cmd_i          = '0;
    fe_cmd_v_i        = 1'b0;
    fetch_req_ready_i = 1'b1;
    fetch_resp_i      = '0;
    fe_queue_ready_i  = 1'b1;
    rng          = 32'h6a03f8cc;
    bp_on        = 1'b0;
    hold_queue   = 1'b0;
    cmd_pending  = 1'b0;
    cmd_next     = '0;
    resp_due     = 1'b0;
    resp_pc      = '0;
    errors       = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    exp_cnt      = 0;
    exp_rd       = 0;
    test_num     = 0;

    $readmemh("tests/fe_input.mem", stim);
    // memory image comes first
    idx = 0;
    while (idx < stim_depth_lp && stim[idx][67:64] == 4'h0)
    begin
      image[stim[idx][63:32]] = stim[idx][31:0];
      idx++;
    end

    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    #4;
    assert (!fetch_req_v_o && !fe_queue_v_o1 && !fe_queue_v_o2 && !fe_cmd_yumi_o)
    else
    begin
      $display("front end is not idle after reset");
      errors++;
    end

    // header, then its expected messages in order
    while (idx < stim_depth_lp && stim[idx][67:64] == 4'h1)
    begin
      hdr = stim[idx];
      idx++;
      exp_cnt = 0;
      exp_rd  = 0;
      while (idx < stim_depth_lp && exp_cnt < max_exp_lp
             && (stim[idx][67:64] == 4'h2 || stim[idx][67:64] == 4'h3))
      begin
        exp_q[exp_cnt] = expected_msg(stim[idx]);
        exp_cnt++;
        idx++;
      end
      test_num++;
      run_test(hdr, test_num);
    end

    assert (test_num > 0 && idx < stim_depth_lp && stim[idx][67:64] == 4'hf)
    else
    begin
      $display("input file has no tests or an unknown record");
      errors++;
    end

    $display("%0d tests run, %0d passed, %0d failed, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

/* tests/fe_input.mem */
// tag_pc_word: tag 0 image word, 1 test header (word bit 0 wait opcode, bit 4 back-pressure,
// bit 8 wait after stream), 2 expected fetch (pc, instr), 3 expected exception (pc, code), f end
0_00001000_00100093
0_00001004_00200113
0_00001008_00300193
0_0000100c_00400213
0_00002000_00500293
0_00002004_00600313
0_00002008_00208463
0_0000200c_00700393
0_00002010_00800413
0_00002014_0080006f
0_00002018_00900493
0_00003000_00a00513
0_00003004_00b00593
0_00003008_00c00613
1_00001000_00000000
2_00001000_00100093
2_00001004_00200113
2_00001008_00300193
2_0000100c_00400213
3_00001010_00000001
1_00002000_00000000
2_00002000_00500293
2_00002004_00600313
2_00002008_00208463
2_0000200c_00700393
2_00002010_00800413
2_00002014_0080006f
3_00002018_00000001
1_00001002_00000000
3_00001002_00000000
1_00003000_00000000
2_00003000_00a00513
2_00003004_00b00593
3_00003008_00000001
1_00001000_00000110
2_00001000_00100093
2_00001004_00200113
2_00001008_00300193
2_0000100c_00400213
f_00000000_00000000

/* compile.f */
hw/fe_pkg.sv
hw/fe_fetch_ctrl.sv
hw/fe_fetch_stage.sv
hw/fe_queue_pack.sv
hw/fe_top.sv
tests/fe_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= fe_tb
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing
FAIL_MSG   ?= Finished with errors
PASS_MSG   ?= Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
